//--- src.f
+incdir+testbench
common/router_pkg.sv
common/pkt_stream_if.sv
source/pkt_fifo.sv
ingress/ingress_arbiter.sv
egress/egress_demux.sv
source/frame_counters.sv
source/phys_port_router.sv
testbench/router_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the router testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f src.f --top-module router_tb -o router_sim

./obj_dir/router_sim | tee sim.log

if grep -q "Regression passed" sim.log; then
    echo "Simulation PASS"
else
    echo "Simulation FAIL"
    exit 1
fi

//--- testbench/router_tests.svh
// Router directed tests
// Packet drivers and test tasks, included into the testbench top
`ifndef ROUTER_TESTS_SVH
`define ROUTER_TESTS_SVH

int burst_len [NUM_PORTS][PKTS_PER_PORT];

// Marker, port, packet number, beat index
function automatic word_t make_word(input int p, input int pkt, input int b);
    make_word = {4'ha, 4'(p), 12'(pkt), 12'(b)};
endfunction

task automatic send_packet(input int p, input int len);
    int   t;
    logic taken;
    for (int b = 0; b < len; b++) begin
        @(negedge phys_port_clk_ifc);
        ing_valid[p] = 1'b1;
        ing_data[p]  = make_word(p, pkt_no[p], b);
        ing_last[p]  = (b == len - 1);
        t     = 0;
        taken = 1'b0;
        while (!taken && t < TIMEOUT) begin
            @(posedge phys_port_clk_ifc);
            taken = ing_ready[p];
            t++;
        end
        if (!taken) begin
            abort_run($sformatf("ingress port %0d never accepted a beat", p));
        end
    end
    @(negedge phys_port_clk_ifc);
    ing_valid[p]   = 1'b0;
    ing_last[p]    = 1'b0;
    pkt_no[p]      = pkt_no[p] + 1;
    sent_frames[p] = sent_frames[p] + 1;
endtask

task automatic send_stream(input int p);
    for (int k = 0; k < PKTS_PER_PORT; k++) begin
        send_packet(p, burst_len[p][k]);
    end
    senders_left = senders_left - 1;
endtask

task automatic wait_drained();
    int t;
    int left;
    t    = 0;
    left = 1;
    while (left != 0 && t < TIMEOUT) begin
        @(negedge phys_port_clk_ifc);
        left = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            left += exp_q[p].size();
        end
        t++;
    end
    if (left != 0) begin
        abort_run("egress ports did not deliver every beat");
    end
    // Counter update after the last handshake
    repeat (2) @(negedge phys_port_clk_ifc);
endtask

task automatic check_all_counts();
    for (int p = 0; p < NUM_PORTS; p++) begin
        check_count("ingress", p, ing_frame_cnt[p], sent_frames[p]);
        check_count("egress", p, egr_frame_cnt[p], sent_frames[p]);
    end
endtask

////////////////////
// Tests

task automatic reset_test();
    int errs;
    errs = err_cnt;
    check_flags("egr_valid after reset", egr_valid, '0, '1);
    check_all_counts();
    report_test("reset", errs);
endtask

task automatic echo_test();
    int errs;
    errs = err_cnt;
    for (int p = 0; p < NUM_PORTS; p++) begin
        send_packet(p, p + 3);
        wait_drained();
    end
    check_all_counts();
    report_test("echo", errs);
endtask

task automatic concurrent_test();
    int errs;
    int v;
    int t;
    errs = err_cnt;
    for (int p = 0; p < NUM_PORTS; p++) begin
        for (int k = 0; k < PKTS_PER_PORT; k++) begin
            take_bits(4, v);
            burst_len[p][k] = v + 1;
        end
    end
    senders_left = NUM_PORTS;
    for (int p = 0; p < NUM_PORTS; p++) begin
        fork
            automatic int q = p;
            send_stream(q);
        join_none
    end
    // Random egress back-pressure while the senders run
    t = 0;
    while (senders_left != 0 && t < TIMEOUT * PKTS_PER_PORT) begin
        @(negedge phys_port_clk_ifc);
        for (int p = 0; p < NUM_PORTS; p++) begin
            take_bits(1, v);
            egr_ready[p] = v[0];
        end
        t++;
    end
    if (senders_left != 0) begin
        abort_run("concurrent senders did not finish");
    end
    egr_ready = '1;
    wait_drained();
    check_all_counts();
    report_test("concurrent", errs);
endtask

task automatic disabled_port_test();
    int                   errs;
    int                   p;
    logic [NUM_PORTS-1:0] mask;
    errs    = err_cnt;
    p       = 2;
    mask    = '0;
    mask[p] = 1'b1;
    @(negedge phys_port_clk_ifc);
    port_enable[p] = 1'b0;
    ing_valid[p]   = 1'b1;
    ing_data[p]    = make_word(p, pkt_no[p], 0);
    ing_last[p]    = 1'b1;
    repeat (20) begin
        @(posedge phys_port_clk_ifc);
        check_flags("ing_ready on disabled port", ing_ready, '0, mask);
        check_flags("egr_valid on disabled port", egr_valid, '0, mask);
    end
    @(negedge phys_port_clk_ifc);
    ing_valid[p] = 1'b0;
    ing_last[p]  = 1'b0;
    check_all_counts();
    port_enable[p] = 1'b1;
    send_packet(p, 5);
    wait_drained();
    check_all_counts();
    report_test("disabled port", errs);
endtask

task automatic counter_clear_test();
    int errs;
    int p;
    errs = err_cnt;
    p    = 1;
    @(negedge phys_port_clk_ifc);
    cnt_clear[p] = 1'b1;
    @(negedge phys_port_clk_ifc);
    cnt_clear[p]   = 1'b0;
    sent_frames[p] = '0;
    @(negedge phys_port_clk_ifc);
    check_all_counts();
    report_test("counter clear", errs);
endtask

`endif

//--- testbench/router_tb.sv
// Router testbench top
// Clock, reset, DUT, scoreboard and the directed test sequence
`timescale 1ns/1ps
`default_nettype none

module router_tb;
    import router_pkg::*;

    localparam int NUM_PORTS     = 4;
    localparam int FIFO_DEPTH    = 16;
    localparam int TIMEOUT       = 4000;
    localparam int PKTS_PER_PORT = 4;

    logic                 phys_port_clk_ifc;
    logic                 rst;
    logic [NUM_PORTS-1:0] port_enable;
    logic [NUM_PORTS-1:0] ing_valid;
    logic [NUM_PORTS-1:0] ing_ready;
    word_t                ing_data [NUM_PORTS];
    logic [NUM_PORTS-1:0] ing_last;
    logic [NUM_PORTS-1:0] egr_valid;
    logic [NUM_PORTS-1:0] egr_ready;
    word_t                egr_data [NUM_PORTS];
    logic [NUM_PORTS-1:0] egr_last;
    logic [NUM_PORTS-1:0] cnt_clear;
    frame_cnt_t           ing_frame_cnt [NUM_PORTS];
    frame_cnt_t           egr_frame_cnt [NUM_PORTS];

    beat_t       exp_q [NUM_PORTS][$];
    frame_cnt_t  sent_frames [NUM_PORTS];
    int          pkt_no [NUM_PORTS];
    logic [31:0] lfsr;
    int          err_cnt;
    int          tests_run;
    int          tests_failed;
    int          senders_left;

    phys_port_router #(
        .NUM_PORTS  ( NUM_PORTS  ),
        .FIFO_DEPTH ( FIFO_DEPTH )
    ) phys_port_router_i (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .rst               ( rst               ),
        .port_enable       ( port_enable       ),
        .ing_valid         ( ing_valid         ),
        .ing_ready         ( ing_ready         ),
        .ing_data          ( ing_data          ),
        .ing_last          ( ing_last          ),
        .egr_valid         ( egr_valid         ),
        .egr_ready         ( egr_ready         ),
        .egr_data          ( egr_data          ),
        .egr_last          ( egr_last          ),
        .cnt_clear         ( cnt_clear         ),
        .ing_frame_cnt     ( ing_frame_cnt     ),
        .egr_frame_cnt     ( egr_frame_cnt     )
    );

    always #2 phys_port_clk_ifc = ~phys_port_clk_ifc;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int v);
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = (v << 1) | int'(lfsr[0]);
        end
    endtask

    ////////////////////
    // Checks

    task automatic check_beat(input int port, input beat_t got, input beat_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %0t: egress port %0d got %h last %b, expected %h last %b",
                     $time, port, got.data, got.last, exp.data, exp.last);
        end
    endtask

    task automatic check_count(input string what, input int port,
                               input frame_cnt_t got, input frame_cnt_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %0t: %s count port %0d is %0d, expected %0d",
                     $time, what, port, got, exp);
        end
    endtask

    task automatic check_flags(input string what, input logic [NUM_PORTS-1:0] got,
                               input logic [NUM_PORTS-1:0] exp,
                               input logic [NUM_PORTS-1:0] mask);
        if ((got & mask) !== (exp & mask)) begin
            err_cnt++;
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got & mask, exp & mask);
        end
    endtask

    task automatic report_test(input string name, input int errs_at_start);
        tests_run++;
        if (err_cnt == errs_at_start) begin
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", name, err_cnt - errs_at_start);
        end
    endtask

    task automatic abort_run(input string what);
        $display("Timeout at %0t: %s", $time, what);
        $display("Regression failed");
        $finish;
    endtask

    // Scoreboard, accepted ingress beats against delivered egress beats
    always @(posedge phys_port_clk_ifc) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (!rst && ing_valid[p] && ing_ready[p]) begin
                exp_q[p].push_back('{data: ing_data[p], last: ing_last[p]});
            end
            if (!rst && egr_valid[p] && egr_ready[p]) begin
                if (exp_q[p].size() == 0) begin
                    err_cnt++;
                    $display("Unexpected beat %h on egress port %0d at %0t",
                             egr_data[p], p, $time);
                end else begin
                    check_beat(p, '{data: egr_data[p], last: egr_last[p]}, exp_q[p].pop_front());
                end
            end
        end
    end

    `include "router_tests.svh"

    initial begin
        phys_port_clk_ifc = 1'b0;
        rst               = 1'b1;
        port_enable       = '1;
        ing_valid         = '0;
        ing_last          = '0;
        ing_data          = '{default: '0};
        egr_ready         = '1;
        cnt_clear         = '0;
        lfsr              = 32'h05a4_2a2a;
        err_cnt           = 0;
        tests_run         = 0;
        tests_failed      = 0;
        senders_left      = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            sent_frames[p] = '0;
            pkt_no[p]      = 0;
        end
        repeat (10) @(posedge phys_port_clk_ifc);
        @(negedge phys_port_clk_ifc);
        rst = 1'b0;

        reset_test();
        echo_test();
        concurrent_test();
        disabled_port_test();
        counter_clear_test();

        $display("Tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/phys_port_router.sv
// Physical port router top level
// Ingress FIFOs, round-robin arbiter, echo demux, egress FIFOs and frame counters
`timescale 1ns/1ps
`default_nettype none

module phys_port_router #(
    parameter int NUM_PORTS  = 4,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                   phys_port_clk_ifc,
    input  logic                   rst,
    input  logic [NUM_PORTS-1:0]   port_enable,
    input  logic [NUM_PORTS-1:0]   ing_valid,
    output logic [NUM_PORTS-1:0]   ing_ready,
    input  router_pkg::word_t      ing_data [NUM_PORTS],
    input  logic [NUM_PORTS-1:0]   ing_last,
    output logic [NUM_PORTS-1:0]   egr_valid,
    input  logic [NUM_PORTS-1:0]   egr_ready,
    output router_pkg::word_t      egr_data [NUM_PORTS],
    output logic [NUM_PORTS-1:0]   egr_last,
    input  logic [NUM_PORTS-1:0]   cnt_clear,
    output router_pkg::frame_cnt_t ing_frame_cnt [NUM_PORTS],
    output router_pkg::frame_cnt_t egr_frame_cnt [NUM_PORTS]
);
    import router_pkg::*;

    logic [NUM_PORTS-1:0] ing_fifo_valid;
    logic [NUM_PORTS-1:0] ing_fifo_ready;
    beat_t                ing_fifo_beat [NUM_PORTS];
    logic [NUM_PORTS-1:0] arb_valid;
    logic [NUM_PORTS-1:0] arb_ready;
    beat_t                arb_beat [NUM_PORTS];
    logic [NUM_PORTS-1:0] dmx_valid;
    logic [NUM_PORTS-1:0] dmx_ready;
    beat_t                dmx_beat [NUM_PORTS];
    beat_t                egr_beat [NUM_PORTS];
    logic [NUM_PORTS-1:0] ing_frame_done;
    logic [NUM_PORTS-1:0] egr_frame_done;

    pkt_stream_if core_stream ();

    ////////////////////
    // Per-port FIFOs

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        // Disabled port accepts nothing
        assign ing_fifo_valid[p] = ing_valid[p] & port_enable[p];
        assign ing_ready[p]      = ing_fifo_ready[p] & port_enable[p];
        assign ing_fifo_beat[p]  = '{data: ing_data[p], last: ing_last[p]};
        assign ing_frame_done[p] = ing_valid[p] & ing_ready[p] & ing_last[p];

        pkt_fifo #(
            .payload_t  ( beat_t     ),
            .FIFO_DEPTH ( FIFO_DEPTH )
        ) ing_fifo_i (
            .phys_port_clk_ifc ( phys_port_clk_ifc ),
            .rst               ( rst               ),
            .in_valid          ( ing_fifo_valid[p] ),
            .in_ready          ( ing_fifo_ready[p] ),
            .in_beat           ( ing_fifo_beat[p]  ),
            .out_valid         ( arb_valid[p]      ),
            .out_ready         ( arb_ready[p]      ),
            .out_beat          ( arb_beat[p]       )
        );

        pkt_fifo #(
            .payload_t  ( beat_t     ),
            .FIFO_DEPTH ( FIFO_DEPTH )
        ) egr_fifo_i (
            .phys_port_clk_ifc ( phys_port_clk_ifc ),
            .rst               ( rst               ),
            .in_valid          ( dmx_valid[p]      ),
            .in_ready          ( dmx_ready[p]      ),
            .in_beat           ( dmx_beat[p]       ),
            .out_valid         ( egr_valid[p]      ),
            .out_ready         ( egr_ready[p]      ),
            .out_beat          ( egr_beat[p]       )
        );

        assign egr_data[p]       = egr_beat[p].data;
        assign egr_last[p]       = egr_beat[p].last;
        assign egr_frame_done[p] = egr_valid[p] & egr_ready[p] & egr_last[p];
    end

    ////////////////////
    // Core path

    ingress_arbiter #(
        .NUM_PORTS ( NUM_PORTS )
    ) ingress_arbiter_i (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .rst               ( rst               ),
        .req_valid         ( arb_valid         ),
        .req_beat          ( arb_beat          ),
        .req_ready         ( arb_ready         ),
        .core              ( core_stream       )
    );

    egress_demux #(
        .NUM_PORTS ( NUM_PORTS )
    ) egress_demux_i (
        .core      ( core_stream ),
        .egr_valid ( dmx_valid   ),
        .egr_beat  ( dmx_beat    ),
        .egr_ready ( dmx_ready   )
    );

    frame_counters #(
        .NUM_PORTS ( NUM_PORTS )
    ) frame_counters_i (
        .phys_port_clk_ifc ( phys_port_clk_ifc ),
        .rst               ( rst               ),
        .ing_frame_done    ( ing_frame_done    ),
        .egr_frame_done    ( egr_frame_done    ),
        .cnt_clear         ( cnt_clear         ),
        .ing_frame_cnt     ( ing_frame_cnt     ),
        .egr_frame_cnt     ( egr_frame_cnt     )
    );

endmodule

`default_nettype wire

//--- source/frame_counters.sv
// Frame counters
// Per-port ingress and egress packet counts with per-port clear
`timescale 1ns/1ps
`default_nettype none

module frame_counters #(
    parameter int NUM_PORTS = 4
) (
    input  logic                   phys_port_clk_ifc,
    input  logic                   rst,
    input  logic [NUM_PORTS-1:0]   ing_frame_done,
    input  logic [NUM_PORTS-1:0]   egr_frame_done,
    input  logic [NUM_PORTS-1:0]   cnt_clear,
    output router_pkg::frame_cnt_t ing_frame_cnt [NUM_PORTS],
    output router_pkg::frame_cnt_t egr_frame_cnt [NUM_PORTS]
);

    always_ff @(posedge phys_port_clk_ifc) begin
        if (rst) begin
            ing_frame_cnt <= '{default: '0};
            egr_frame_cnt <= '{default: '0};
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                // Clear wins over a same-cycle frame
                if (cnt_clear[p]) begin
                    ing_frame_cnt[p] <= '0;
                    egr_frame_cnt[p] <= '0;
                end else begin
                    if (ing_frame_done[p]) begin
                        ing_frame_cnt[p] <= ing_frame_cnt[p] + 1'b1;
                    end
                    if (egr_frame_done[p]) begin
                        egr_frame_cnt[p] <= egr_frame_cnt[p] + 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- egress/egress_demux.sv
// Egress demux
// Steers core stream beats to the egress FIFO named by the port tag
`timescale 1ns/1ps
`default_nettype none

module egress_demux #(
    parameter int NUM_PORTS = 4
) (
    pkt_stream_if.dst            core,
    output logic [NUM_PORTS-1:0] egr_valid,
    output router_pkg::beat_t    egr_beat [NUM_PORTS],
    input  logic [NUM_PORTS-1:0] egr_ready
);

    // Echo routing sends each beat out on its source port
    always_comb begin
        egr_valid                  = '0;
        egr_valid[int'(core.port)] = core.valid;
    end

    assign core.ready = egr_ready[int'(core.port)];

    // Every FIFO sees the data and only the tagged one sees valid
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_beat
        assign egr_beat[p] = core.beat;
    end

endmodule

`default_nettype wire

//--- ingress/ingress_arbiter.sv
// Ingress arbiter
// Round-robin over the ingress FIFOs, one whole packet per grant
`timescale 1ns/1ps
`default_nettype none

module ingress_arbiter #(
    parameter int NUM_PORTS = 4
) (
    input  logic                 phys_port_clk_ifc,
    input  logic                 rst,
    input  logic [NUM_PORTS-1:0] req_valid,
    input  router_pkg::beat_t    req_beat [NUM_PORTS],
    output logic [NUM_PORTS-1:0] req_ready,
    pkt_stream_if.src            core
);
    import router_pkg::*;

    port_idx_t    grant_q;
    port_idx_t    rr_pick;
    port_idx_t    sel;
    logic         busy;
    tagged_beat_t head;

    ////////////////////
    // Port selection

    // Nearest requesting port after the last grant wins
    always_comb begin
        int idx;
        rr_pick = grant_q;
        for (int i = NUM_PORTS; i >= 1; i--) begin
            idx = (int'(grant_q) + i) % NUM_PORTS;
            if (req_valid[idx]) begin
                rr_pick = port_idx_t'(idx);
            end
        end
    end

    // Held grant for the rest of a packet or a stalled first beat
    assign sel = busy ? grant_q : rr_pick;

    ////////////////////
    // Core stream

    assign head       = '{beat: req_beat[int'(sel)], port: sel};
    assign core.valid = req_valid[int'(sel)];
    assign core.beat  = head.beat;
    assign core.port  = head.port;

    always_comb begin
        req_ready              = '0;
        req_ready[int'(sel)]   = core.ready;
    end

    ////////////////////
    // Grant state

    always_ff @(posedge phys_port_clk_ifc) begin
        if (rst) begin
            busy    <= 1'b0;
            grant_q <= port_idx_t'(NUM_PORTS - 1);
        end else if (core.valid) begin
            grant_q <= sel;
            // Released only once the last beat has gone
            busy    <= ~(core.ready & core.beat.last);
        end
    end

endmodule

`default_nettype wire

//--- source/pkt_fifo.sv
// Synchronous packet FIFO
// Circular buffer feeding a registered output stage
`timescale 1ns/1ps
`default_nettype none

module pkt_fifo #(
    parameter type payload_t  = router_pkg::beat_t,
    parameter int  FIFO_DEPTH = 16
) (
    input  logic     phys_port_clk_ifc,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_beat,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_beat
);

    localparam int AW = $clog2(FIFO_DEPTH);

    payload_t      mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          wr_en;
    logic          load;
    logic          mem_wr;
    logic          mem_rd;

    assign in_ready = (count != (AW+1)'(FIFO_DEPTH));
    assign wr_en    = in_valid & in_ready;
    // Output register empty or being drained
    assign load     = ~out_valid | out_ready;
    assign mem_rd   = load & (count != '0);
    // Empty buffer writes straight into the output register
    assign mem_wr   = wr_en & ~(load & (count == '0));

    always_ff @(posedge phys_port_clk_ifc) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (mem_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (mem_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (AW+1)'(mem_wr) - (AW+1)'(mem_rd);
            if (load) begin
                out_valid <= mem_rd | wr_en;
            end
        end
    end

    always_ff @(posedge phys_port_clk_ifc) begin
        if (mem_wr) begin
            mem[wr_ptr] <= in_beat;
        end
        if (mem_rd) begin
            out_beat <= mem[rd_ptr];
        end else if (load && wr_en) begin
            out_beat <= in_beat;
        end
    end

endmodule

`default_nettype wire

//--- common/pkt_stream_if.sv
// Core packet stream
// One beat per valid/ready transfer, tagged with its source port
`timescale 1ns/1ps
`default_nettype none

interface pkt_stream_if;
    import router_pkg::*;

    logic      valid;
    logic      ready;
    beat_t     beat;
    port_idx_t port;

    // Arbiter side
    modport src (output valid, output beat, output port, input ready);

    // Demux side
    modport dst (input valid, input beat, input port, output ready);

endinterface

`default_nettype wire

//--- common/router_pkg.sv
// Router package
// Word, beat, port tag and counter types shared by the router blocks
`default_nettype none

package router_pkg;

    ////////////////////
    // Size limits

    localparam int DATA_W     = 32;
    localparam int MAX_PORTS  = 8;
    localparam int PORT_IDX_W = $clog2(MAX_PORTS);
    localparam int CNT_W      = 32;

    ////////////////////
    // Types

    typedef logic [DATA_W-1:0]     word_t;
    typedef logic [PORT_IDX_W-1:0] port_idx_t;
    typedef logic [CNT_W-1:0]      frame_cnt_t;

    // One stream beat, last marks the end of a packet
    typedef struct packed {
        word_t data;
        logic  last;
    } beat_t;

    // Core stream payload
    typedef struct packed {
        beat_t     beat;
        port_idx_t port;
    } tagged_beat_t;

endpackage

`default_nettype wire
